// ==== logic/eth_pkg.sv ====
`default_nettype none

package eth_pkg;

   // Register space and receive buffer geometry
   localparam int ETH_ADDR_W     = 12;
   localparam int BUF_ADDR_W_DEF = 11;

   // Addresses with this bit set hit the receive buffer window
   localparam int WIN_BIT = ETH_ADDR_W - 1;

   // Register offsets
   typedef enum logic [ETH_ADDR_W-1:0] {
      REG_STATUS  = 12'h000,
      REG_CONTROL = 12'h004,
      REG_MAC_LO  = 12'h008,
      REG_MAC_HI  = 12'h00C,
      REG_SCRATCH = 12'h010
   } eth_reg_e;

   typedef enum logic [1:0] {
      RESP_OKAY   = 2'b00,
      RESP_SLVERR = 2'b10
   } axil_resp_e;

   // AXI4-Lite channel payloads
   typedef struct packed {
      logic [ETH_ADDR_W-1:0] addr;
   } axil_aw_t;

   typedef struct packed {
      logic [31:0] data;
      logic [3:0]  strb;
   } axil_w_t;

   typedef struct packed {
      logic [ETH_ADDR_W-1:0] addr;
   } axil_ar_t;

   typedef struct packed {
      logic [31:0] data;
      axil_resp_e  resp;
   } axil_r_t;

   // Receive engine states
   typedef enum logic [2:0] {
      RX_IDLE,
      RX_WAIT_SFD,
      RX_DATA,
      RX_DROP,
      RX_DONE
   } rx_state_e;

   typedef struct packed {
      logic                      ready;
      logic [BUF_ADDR_W_DEF-1:0] length;
   } rx_status_t;

   // Byte write into the receive buffer
   typedef struct packed {
      logic                      en;
      logic [BUF_ADDR_W_DEF-1:0] addr;
      logic [7:0]                data;
   } buf_wr_t;

endpackage

`default_nettype wire

// ==== logic/eth_rx_buffer.sv ====
`default_nettype none

module eth_rx_buffer #(
   parameter int BUF_ADDR_W = eth_pkg::BUF_ADDR_W_DEF
) (
   input  logic                  RX_CLK,
   input  eth_pkg::buf_wr_t      buf_wr,
   input  logic [BUF_ADDR_W-1:0] rd_addr,
   output logic [7:0]            rd_data
);

   logic [7:0] mem [0:(2**BUF_ADDR_W)-1];

   // Write side, fed by the receive engine
   always_ff @(posedge RX_CLK) begin
      if (buf_wr.en) begin
         mem[buf_wr.addr[BUF_ADDR_W-1:0]] <= buf_wr.data;
      end
   end

   // Host side, one cycle read latency
   always_ff @(posedge RX_CLK) begin
      rd_data <= mem[rd_addr];
   end

endmodule

`default_nettype wire

// ==== logic/eth_rx_mac.sv ====
`default_nettype none

module eth_rx_mac #(
   parameter int BUF_ADDR_W = eth_pkg::BUF_ADDR_W_DEF
) (
   input  logic                RX_CLK,
   input  logic                rst,
   input  logic                rx_arm,
   input  logic [47:0]         mac_addr,
   input  logic [3:0]          rx_data,
   input  logic                rx_dv,
   output eth_pkg::buf_wr_t    buf_wr,
   output eth_pkg::rx_status_t rx_status
);

   eth_pkg::rx_state_e    state;
   logic                  nib_phase;
   logic [3:0]            nib_lo;
   logic [BUF_ADDR_W-1:0] byte_cnt;
   logic                  match_sta;
   logic                  match_bc;
   logic [7:0]            rx_byte;
   logic [7:0]            exp_byte;
   logic                  sta_next;
   logic                  bc_next;
   logic                  cnt_full;

   // Low nibble comes first on the wire
   assign rx_byte  = {rx_data, nib_lo};
   assign cnt_full = &byte_cnt;

   // Destination byte expected at this position, first byte is the MSB of the address
   always_comb begin
      case (byte_cnt)
         0:       exp_byte = mac_addr[47:40];
         1:       exp_byte = mac_addr[39:32];
         2:       exp_byte = mac_addr[31:24];
         3:       exp_byte = mac_addr[23:16];
         4:       exp_byte = mac_addr[15:8];
         5:       exp_byte = mac_addr[7:0];
         default: exp_byte = 8'h00;
      endcase
   end

   assign sta_next = match_sta & (rx_byte == exp_byte);
   assign bc_next  = match_bc & (rx_byte == 8'hFF);

   always_ff @(posedge RX_CLK or posedge rst) begin
      if (rst) begin
         state     <= eth_pkg::RX_IDLE;
         nib_phase <= 1'b0;
         nib_lo    <= '0;
         byte_cnt  <= '0;
         match_sta <= 1'b0;
         match_bc  <= 1'b0;
         buf_wr    <= '0;
         rx_status <= '0;
      end else begin
         buf_wr.en <= 1'b0;
         if (rx_arm) begin
            state     <= eth_pkg::RX_WAIT_SFD;
            byte_cnt  <= '0;
            nib_lo    <= '0;
            rx_status <= '0;
         end else begin
            case (state)
               eth_pkg::RX_WAIT_SFD: begin
                  nib_lo <= rx_dv ? rx_data : 4'h0;
                  // SFD 0xD5 shows up as nibble 5 followed by D
                  if (rx_dv && rx_data == 4'hD && nib_lo == 4'h5) begin
                     state     <= eth_pkg::RX_DATA;
                     nib_phase <= 1'b0;
                     byte_cnt  <= '0;
                     match_sta <= 1'b1;
                     match_bc  <= 1'b1;
                  end
               end
               eth_pkg::RX_DATA: begin
                  if (!rx_dv) begin
                     // Frames too short to carry an address are dropped
                     if (byte_cnt >= 6) begin
                        state            <= eth_pkg::RX_DONE;
                        rx_status.ready  <= 1'b1;
                        rx_status.length <= byte_cnt;
                     end else begin
                        state <= eth_pkg::RX_WAIT_SFD;
                     end
                  end else if (!nib_phase) begin
                     nib_lo    <= rx_data;
                     nib_phase <= 1'b1;
                  end else begin
                     nib_phase   <= 1'b0;
                     buf_wr.en   <= ~cnt_full;
                     buf_wr.addr <= byte_cnt;
                     buf_wr.data <= rx_byte;
                     // Count sticks at the last buffer entry
                     if (!cnt_full) begin
                        byte_cnt <= byte_cnt + 1'b1;
                     end
                     if (byte_cnt < 6) begin
                        match_sta <= sta_next;
                        match_bc  <= bc_next;
                        if (byte_cnt == 5 && !sta_next && !bc_next) begin
                           state <= eth_pkg::RX_DROP;
                        end
                     end
                  end
               end
               eth_pkg::RX_DROP: begin
                  if (!rx_dv) begin
                     state <= eth_pkg::RX_WAIT_SFD;
                  end
               end
               // Idle and done only leave on arm
               default: ;
            endcase
         end
      end
   end

   a_no_idle_write: assert property (@(posedge RX_CLK) disable iff (rst)
      (state == eth_pkg::RX_IDLE || state == eth_pkg::RX_DONE) |-> !buf_wr.en);

endmodule

`default_nettype wire

// ==== logic/eth_regs.sv ====
`default_nettype none

module eth_regs #(
   parameter logic [47:0] DEFAULT_MAC    = 48'h02_00_00_00_00_01,
   parameter int          BUF_ADDR_W     = eth_pkg::BUF_ADDR_W_DEF,
   parameter int          PHY_RST_CYCLES = 15
) (
   input  logic                   RX_CLK,
   input  logic                   rst,
   input  eth_pkg::axil_aw_t      aw,
   input  logic                   aw_valid,
   output logic                   aw_ready,
   input  eth_pkg::axil_w_t       w,
   input  logic                   w_valid,
   output logic                   w_ready,
   output eth_pkg::axil_resp_e    b_resp,
   output logic                   b_valid,
   input  logic                   b_ready,
   input  eth_pkg::axil_ar_t      ar,
   input  logic                   ar_valid,
   output logic                   ar_ready,
   output eth_pkg::axil_r_t       r,
   output logic                   r_valid,
   input  logic                   r_ready,
   input  eth_pkg::rx_status_t    rx_status,
   output logic [BUF_ADDR_W-1:0]  buf_rd_addr,
   input  logic [7:0]             buf_rd_data,
   output logic                   rx_arm,
   output logic [47:0]            mac_addr,
   output logic                   eth_resetn
);

   localparam int PHY_CNT_W = $clog2(PHY_RST_CYCLES + 1);
   localparam logic [PHY_CNT_W-1:0] PHY_CNT_MAX = PHY_RST_CYCLES[PHY_CNT_W-1:0];

   logic                 wr_fire;
   logic                 ar_fire;
   logic [31:0]          scratch;
   logic [31:0]          reg_rd_data;
   logic [31:0]          rd_data_q;
   logic                 rd_first;
   logic [PHY_CNT_W-1:0] phy_cnt;

   // AW and W are taken together, and only with no B outstanding
   assign aw_ready = w_valid & ~b_valid;
   assign w_ready  = aw_valid & ~b_valid;
   assign wr_fire  = aw_valid & w_valid & ~b_valid;
   assign b_resp   = eth_pkg::RESP_OKAY;

   // Byte strobes are not used, every write is a full word
   always_ff @(posedge RX_CLK or posedge rst) begin
      if (rst) begin
         b_valid  <= 1'b0;
         rx_arm   <= 1'b0;
         mac_addr <= DEFAULT_MAC;
         scratch  <= '0;
      end else begin
         rx_arm <= 1'b0;
         if (wr_fire) begin
            b_valid <= 1'b1;
            case (aw.addr)
               eth_pkg::REG_CONTROL: rx_arm <= w.data[0];
               eth_pkg::REG_MAC_LO:  mac_addr[23:0] <= w.data[23:0];
               eth_pkg::REG_MAC_HI:  mac_addr[47:24] <= w.data[23:0];
               eth_pkg::REG_SCRATCH: scratch <= w.data;
               default: ;
            endcase
         end else if (b_ready) begin
            b_valid <= 1'b0;
         end
      end
   end

   assign ar_ready    = ~r_valid;
   assign ar_fire     = ar_valid & ~r_valid;
   assign buf_rd_addr = ar.addr[BUF_ADDR_W-1:0];

   // Register read mux, control bit 0 always reads as zero
   always_comb begin
      reg_rd_data = '0;
      case (ar.addr)
         eth_pkg::REG_STATUS:  reg_rd_data = {5'd0, rx_status.length, 15'd0, rx_status.ready};
         eth_pkg::REG_MAC_LO:  reg_rd_data = {8'd0, mac_addr[23:0]};
         eth_pkg::REG_MAC_HI:  reg_rd_data = {8'd0, mac_addr[47:24]};
         eth_pkg::REG_SCRATCH: reg_rd_data = scratch;
         default:              reg_rd_data = '0;
      endcase
   end

   always_ff @(posedge RX_CLK or posedge rst) begin
      if (rst) begin
         r_valid  <= 1'b0;
         rd_first <= 1'b0;
      end else begin
         rd_first <= ar_fire & ar.addr[eth_pkg::WIN_BIT];
         if (ar_fire) begin
            r_valid <= 1'b1;
         end else if (r_ready) begin
            r_valid <= 1'b0;
         end
      end
   end

   // Buffer byte arrives one cycle after AR, then it is held in the payload
   always_ff @(posedge RX_CLK) begin
      if (ar_fire) begin
         rd_data_q <= reg_rd_data;
      end else if (rd_first) begin
         rd_data_q <= {24'd0, buf_rd_data};
      end
   end

   always_comb begin
      r.data = rd_first ? {24'd0, buf_rd_data} : rd_data_q;
      r.resp = eth_pkg::RESP_OKAY;
   end

   // PHY held in reset for a fixed count after core reset
   always_ff @(posedge RX_CLK or posedge rst) begin
      if (rst) begin
         phy_cnt    <= '0;
         eth_resetn <= 1'b0;
      end else begin
         if (phy_cnt != PHY_CNT_MAX) begin
            phy_cnt <= phy_cnt + 1'b1;
         end
         eth_resetn <= (phy_cnt == PHY_CNT_MAX);
      end
   end

   a_b_hold: assert property (@(posedge RX_CLK) disable iff (rst)
      b_valid && !b_ready |=> b_valid);

   // Read response stays up with the same payload until taken
   a_r_hold: assert property (@(posedge RX_CLK) disable iff (rst)
      r_valid && !r_ready |=> r_valid && $stable(r));

   a_arm_pulse: assert property (@(posedge RX_CLK) disable iff (rst)
      rx_arm |=> !rx_arm);

endmodule

`default_nettype wire

// ==== logic/eth_rx_core.sv ====
`default_nettype none

module eth_rx_core #(
   parameter int          BUF_ADDR_W     = eth_pkg::BUF_ADDR_W_DEF,
   parameter logic [47:0] DEFAULT_MAC    = 48'h02_00_00_00_00_01,
   parameter int          PHY_RST_CYCLES = 15
) (
   input  logic                RX_CLK,
   input  logic                rst,
   input  eth_pkg::axil_aw_t   aw,
   input  logic                aw_valid,
   output logic                aw_ready,
   input  eth_pkg::axil_w_t    w,
   input  logic                w_valid,
   output logic                w_ready,
   output eth_pkg::axil_resp_e b_resp,
   output logic                b_valid,
   input  logic                b_ready,
   input  eth_pkg::axil_ar_t   ar,
   input  logic                ar_valid,
   output logic                ar_ready,
   output eth_pkg::axil_r_t    r,
   output logic                r_valid,
   input  logic                r_ready,
   input  logic [3:0]          rx_data,
   input  logic                rx_dv,
   output logic                eth_resetn
);

   logic                  rx_arm;
   logic [47:0]           mac_addr;
   eth_pkg::rx_status_t   rx_status;
   eth_pkg::buf_wr_t      buf_wr;
   logic [BUF_ADDR_W-1:0] buf_rd_addr;
   logic [7:0]            buf_rd_data;

   eth_regs #(
      .DEFAULT_MAC   (DEFAULT_MAC),
      .BUF_ADDR_W    (BUF_ADDR_W),
      .PHY_RST_CYCLES(PHY_RST_CYCLES)
   ) regs (
      .RX_CLK     (RX_CLK),
      .rst        (rst),
      .aw         (aw),
      .aw_valid   (aw_valid),
      .aw_ready   (aw_ready),
      .w          (w),
      .w_valid    (w_valid),
      .w_ready    (w_ready),
      .b_resp     (b_resp),
      .b_valid    (b_valid),
      .b_ready    (b_ready),
      .ar         (ar),
      .ar_valid   (ar_valid),
      .ar_ready   (ar_ready),
      .r          (r),
      .r_valid    (r_valid),
      .r_ready    (r_ready),
      .rx_status  (rx_status),
      .buf_rd_addr(buf_rd_addr),
      .buf_rd_data(buf_rd_data),
      .rx_arm     (rx_arm),
      .mac_addr   (mac_addr),
      .eth_resetn (eth_resetn)
   );

   eth_rx_mac #(
      .BUF_ADDR_W(BUF_ADDR_W)
   ) rx_mac (
      .RX_CLK   (RX_CLK),
      .rst      (rst),
      .rx_arm   (rx_arm),
      .mac_addr (mac_addr),
      .rx_data  (rx_data),
      .rx_dv    (rx_dv),
      .buf_wr   (buf_wr),
      .rx_status(rx_status)
   );

   eth_rx_buffer #(
      .BUF_ADDR_W(BUF_ADDR_W)
   ) rx_buffer (
      .RX_CLK (RX_CLK),
      .buf_wr (buf_wr),
      .rd_addr(buf_rd_addr),
      .rd_data(buf_rd_data)
   );

endmodule

`default_nettype wire

// ==== test/eth_rx_tb.sv ====
`default_nettype none

module eth_rx_tb;

   localparam int          BUF_ADDR_W      = eth_pkg::BUF_ADDR_W_DEF;
   localparam logic [47:0] DEFAULT_MAC     = 48'h02_12_34_56_78_9A;
   localparam int          PHY_RST_CYCLES  = 15;
   localparam int          MAX_LEN         = 64;
   localparam int          NUM_FRAMES      = 5;
   localparam int          WATCHDOG_CYCLES = NUM_FRAMES * (MAX_LEN + 8) * 2 + 20000;
   localparam logic [11:0] WIN_BASE        = 12'h800;

   logic                RX_CLK;
   logic                rst;
   eth_pkg::axil_aw_t   aw;
   logic                aw_valid;
   logic                aw_ready;
   eth_pkg::axil_w_t    w;
   logic                w_valid;
   logic                w_ready;
   eth_pkg::axil_resp_e b_resp;
   logic                b_valid;
   logic                b_ready;
   eth_pkg::axil_ar_t   ar;
   logic                ar_valid;
   logic                ar_ready;
   eth_pkg::axil_r_t    r;
   logic                r_valid;
   logic                r_ready;
   logic [3:0]          rx_data;
   logic                rx_dv;
   logic                eth_resetn;

   integer      seed;
   int          errors;
   int          proto_errors;
   int          checks;
   logic        stall_en;
   logic [47:0] station;
   logic [7:0]  frame [0:MAX_LEN-1];
   int          frame_len;

   eth_rx_core #(
      .BUF_ADDR_W    (BUF_ADDR_W),
      .DEFAULT_MAC   (DEFAULT_MAC),
      .PHY_RST_CYCLES(PHY_RST_CYCLES)
   ) uut (.*);

   initial begin
      RX_CLK = 1'b0;
      forever #50 RX_CLK = ~RX_CLK;
   end

   // Accepted frames carry a station or broadcast destination in bytes 0..5
   function automatic eth_pkg::rx_status_t expect_frame(input logic [7:0] bytes [0:MAX_LEN-1],
         input int len, input logic [47:0] mac);
      eth_pkg::rx_status_t res;
      logic [47:0]         dest;
      res  = '0;
      dest = '0;
      for (int i = 0; i < 6; i++) begin
         dest = {dest[39:0], bytes[i]};
      end
      if (len >= 6 && (dest == mac || dest == '1)) begin
         res.ready  = 1'b1;
         // Length field tops out at its largest count
         res.length = (len > 2**BUF_ADDR_W - 1) ? '1 : len[BUF_ADDR_W-1:0];
      end
      return res;
   endfunction

   task automatic check_word(input logic [31:0] got, input logic [31:0] exp, input string what);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("error at %0t: %s read 0x%08h, expected 0x%08h", $time, what, got, exp);
      end
   endtask

   task automatic check_resp(input eth_pkg::axil_resp_e got, input eth_pkg::axil_resp_e exp,
         input string what);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("error at %0t: %s is %0d, expected %0d", $time, what, got, exp);
      end
   endtask

   task automatic check_status(input eth_pkg::rx_status_t got, input eth_pkg::rx_status_t exp,
         input string what);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("error at %0t: %s status ready=%0b length=%0d, expected ready=%0b length=%0d",
                  $time, what, got.ready, got.length, exp.ready, exp.length);
      end
   endtask

   task automatic check_byte(input logic [7:0] got, input logic [7:0] exp, input int idx);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("error at %0t: buffer byte %0d is 0x%02h, expected 0x%02h",
                  $time, idx, got, exp);
      end
   endtask

   task automatic axil_write(input logic [11:0] addr, input logic [31:0] data);
      logic done;
      @(negedge RX_CLK);
      aw.addr  = addr;
      w.data   = data;
      w.strb   = 4'hF;
      aw_valid = 1'b1;
      w_valid  = 1'b1;
      #1;
      while (!(aw_ready && w_ready)) begin
         @(negedge RX_CLK);
         #1;
      end
      @(negedge RX_CLK);
      if (stall_en) begin
         // Second request to an unused offset has to wait behind the open B
         aw.addr = 12'h020;
         w.data  = $random(seed);
      end else begin
         aw_valid = 1'b0;
         w_valid  = 1'b0;
      end
      done = 1'b0;
      while (!done) begin
         b_ready = stall_en ? (($random(seed) & 3) == 0) : 1'b1;
         #1;
         if (!b_valid) begin
            proto_errors++;
            $display("Write response went missing before it was taken at %0t", $time);
            done = 1'b1;
         end else if (b_ready) begin
            check_resp(b_resp, eth_pkg::RESP_OKAY, "write response");
            done = 1'b1;
         end
         @(negedge RX_CLK);
      end
      b_ready  = 1'b0;
      aw_valid = 1'b0;
      w_valid  = 1'b0;
   endtask

   task automatic axil_read(input logic [11:0] addr, output logic [31:0] data);
      logic done;
      logic first;
      data = '0;
      @(negedge RX_CLK);
      ar.addr  = addr;
      ar_valid = 1'b1;
      #1;
      while (!ar_ready) begin
         @(negedge RX_CLK);
         #1;
      end
      @(negedge RX_CLK);
      if (stall_en) begin
         ar.addr = 12'h024;
      end else begin
         ar_valid = 1'b0;
      end
      done  = 1'b0;
      first = 1'b1;
      while (!done) begin
         r_ready = stall_en ? (($random(seed) & 3) == 0) : 1'b1;
         #1;
         if (!r_valid) begin
            proto_errors++;
            if (first) begin
               $display("Read response did not follow its request by one cycle at %0t", $time);
            end else begin
               $display("Read response went missing before it was taken at %0t", $time);
            end
            done = 1'b1;
         end else if (r_ready) begin
            data = r.data;
            check_resp(r.resp, eth_pkg::RESP_OKAY, "read response");
            done = 1'b1;
         end
         first = 1'b0;
         @(negedge RX_CLK);
      end
      r_ready  = 1'b0;
      ar_valid = 1'b0;
   endtask

   task automatic build_frame(input logic [47:0] dest, input int len);
      for (int i = 0; i < len; i++) begin
         if (i < 6) begin
            frame[i] = dest[47 - 8*i -: 8];
         end else begin
            frame[i] = 8'($random(seed));
         end
      end
      frame_len = len;
   endtask

   // Preamble and SFD, then the frame, low nibble first
   task automatic send_frame();
      logic [7:0] b;
      for (int i = 0; i < frame_len + 8; i++) begin
         if (i < 7) begin
            b = 8'h55;
         end else if (i == 7) begin
            b = 8'hD5;
         end else begin
            b = frame[i-8];
         end
         @(negedge RX_CLK);
         rx_dv   = 1'b1;
         rx_data = b[3:0];
         @(negedge RX_CLK);
         rx_data = b[7:4];
      end
      @(negedge RX_CLK);
      rx_dv   = 1'b0;
      rx_data = 4'h0;
   endtask

   task automatic verify_frame(input string what);
      logic [31:0]         rd;
      eth_pkg::rx_status_t got;
      eth_pkg::rx_status_t exp;
      exp = expect_frame(frame, frame_len, station);
      axil_read(eth_pkg::REG_STATUS, rd);
      got.ready  = rd[0];
      got.length = rd[26:16];
      check_status(got, exp, what);
      if (exp.ready) begin
         for (int i = 0; i < int'(exp.length); i++) begin
            axil_read(WIN_BASE | 12'(i), rd);
            check_byte(rd[7:0], frame[i], i);
         end
      end
   endtask

   // Bus rules checked on every cycle
   initial begin : protocol_monitor
      logic             prev_b_valid;
      logic             prev_b_ready;
      logic             prev_r_valid;
      logic             prev_r_ready;
      eth_pkg::axil_r_t prev_r;
      prev_b_valid = 1'b0;
      prev_b_ready = 1'b0;
      prev_r_valid = 1'b0;
      prev_r_ready = 1'b0;
      prev_r       = '0;
      @(negedge rst);
      forever begin
         @(negedge RX_CLK);
         #1;
         if (b_valid && (aw_ready || w_ready)) begin
            proto_errors++;
            $display("Write request offered a handshake while a response was pending at %0t",
                     $time);
         end
         if (r_valid && ar_ready) begin
            proto_errors++;
            $display("Read request offered a handshake while a response was pending at %0t",
                     $time);
         end
         if (prev_b_valid && !prev_b_ready && !b_valid) begin
            proto_errors++;
            $display("Write response dropped without being taken at %0t", $time);
         end
         if (prev_r_valid && !prev_r_ready && (!r_valid || r !== prev_r)) begin
            proto_errors++;
            $display("Read response dropped or changed while stalled at %0t", $time);
         end
         prev_b_valid = b_valid;
         prev_b_ready = b_ready;
         prev_r_valid = r_valid;
         prev_r_ready = r_ready;
         prev_r       = r;
      end
   end

   initial begin : watchdog
      repeat (WATCHDOG_CYCLES) @(posedge RX_CLK);
      $display("Timeout: the test did not finish within %0d clock cycles", WATCHDOG_CYCLES);
      $display("STATUS: FAIL");
      $finish;
   end

   initial begin : main_sequence
      logic [31:0] rd;
      logic [31:0] value;
      logic [47:0] new_mac;
      int          n;
      seed         = 15;
      errors       = 0;
      proto_errors = 0;
      checks       = 0;
      stall_en     = 1'b0;
      station      = DEFAULT_MAC;
      frame_len    = 0;
      rst          = 1'b1;
      aw           = '0;
      aw_valid     = 1'b0;
      w            = '0;
      w_valid      = 1'b0;
      b_ready      = 1'b0;
      ar           = '0;
      ar_valid     = 1'b0;
      r_ready      = 1'b0;
      rx_data      = 4'h0;
      rx_dv        = 1'b0;

      repeat (2) @(posedge RX_CLK);
      @(negedge RX_CLK);
      rst = 1'b0;

      // PHY reset release
      n = 0;
      while (eth_resetn !== 1'b1) begin
         @(negedge RX_CLK);
         n++;
      end
      checks++;
      if (n != PHY_RST_CYCLES + 1) begin
         errors++;
         $display("error at %0t: ETH_RESETN rose after %0d cycles, expected %0d",
                  $time, n, PHY_RST_CYCLES + 1);
      end
      axil_read(eth_pkg::REG_STATUS, rd);
      check_word(rd, 32'h0, "STATUS after reset");
      axil_read(eth_pkg::REG_MAC_LO, rd);
      check_word(rd, {8'h00, DEFAULT_MAC[23:0]}, "MAC_LO after reset");
      axil_read(eth_pkg::REG_MAC_HI, rd);
      check_word(rd, {8'h00, DEFAULT_MAC[47:24]}, "MAC_HI after reset");

      // Register access
      axil_write(eth_pkg::REG_SCRATCH, 32'hA5C3_0F1E);
      axil_read(eth_pkg::REG_SCRATCH, rd);
      check_word(rd, 32'hA5C3_0F1E, "SCRATCH");
      new_mac = 48'h0A_BB_CC_DD_EE_11;
      axil_write(eth_pkg::REG_MAC_LO, {8'h00, new_mac[23:0]});
      axil_write(eth_pkg::REG_MAC_HI, {8'h00, new_mac[47:24]});
      axil_read(eth_pkg::REG_MAC_LO, rd);
      check_word(rd, {8'h00, new_mac[23:0]}, "MAC_LO");
      axil_read(eth_pkg::REG_MAC_HI, rd);
      check_word(rd, {8'h00, new_mac[47:24]}, "MAC_HI");
      station = new_mac;
      axil_write(eth_pkg::REG_CONTROL, 32'h1);
      axil_read(eth_pkg::REG_CONTROL, rd);
      check_word(rd, 32'h0, "CONTROL");

      // Station frame, the arm above is still in effect
      build_frame(station, 40);
      send_frame();
      verify_frame("station frame");

      // Broadcast, then re-arm and a foreign frame that must vanish
      axil_write(eth_pkg::REG_CONTROL, 32'h1);
      build_frame(48'hFFFF_FFFF_FFFF, 30);
      send_frame();
      verify_frame("broadcast frame");
      axil_write(eth_pkg::REG_CONTROL, 32'h1);
      axil_read(eth_pkg::REG_STATUS, rd);
      check_word(rd, 32'h0, "STATUS after re-arm");
      build_frame(48'h0A_BB_CC_DD_EE_12, 50);
      send_frame();
      repeat (20) @(negedge RX_CLK);
      verify_frame("foreign frame");
      build_frame(station, MAX_LEN);
      send_frame();
      verify_frame("frame after drop");

      // Responses held back by random BREADY and RREADY stalls
      stall_en = 1'b1;
      repeat (6) begin
         value = $random(seed);
         axil_write(eth_pkg::REG_SCRATCH, value);
         axil_read(eth_pkg::REG_SCRATCH, rd);
         check_word(rd, value, "SCRATCH under stalls");
      end
      verify_frame("frame under stalls");
      stall_en = 1'b0;

      checks++;
      if (eth_resetn !== 1'b1) begin
         errors++;
         $display("error at %0t: ETH_RESETN dropped after release", $time);
      end

      $display("Checks: %0d, value errors: %0d, protocol errors: %0d",
               checks, errors, proto_errors);
      if (errors == 0 && proto_errors == 0) begin
         $display("STATUS: PASS");
      end else begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== build.f ====
logic/eth_pkg.sv
logic/eth_rx_buffer.sv
logic/eth_rx_mac.sv
logic/eth_regs.sv
logic/eth_rx_core.sv
test/eth_rx_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the eth_rx_core testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module eth_rx_tb -f build.f -o eth_rx_sim
./obj_dir/eth_rx_sim | tee sim.log

if grep -q "STATUS: FAIL" sim.log; then
   echo "Simulation failed, see sim.log"
   exit 1
fi
echo "Simulation passed"
